// File: rtl/exp_tile.sv
// Lane-parallel exp(x - offset) on one tile, base-2 shift with linear fraction, purely combinational
module exp_tile (
    input  softmax_pkg::tile_t x,
    input  softmax_pkg::elem_t offset,
    output softmax_pkg::tile_t y
);
    import softmax_pkg::*;

    // exp(d) = 2^(d*log2e) = 2^k * 2^f, with 2^f taken as 1 + f
    for (genvar i = 0; i < TILE_SIZE; i++) begin : g_lane
        elem_t             diff;
        elem_t             d;
        logic signed [63:0] prod;
        logic signed [31:0] ipart;      // floor of the scaled value, never positive
        logic [ELEM_W-1:0]  mant;
        logic [4:0]         sh;

        assign diff = x[i] - offset;
        assign d    = (diff > 0) ? '0 : diff;  // Softmax inputs never sit above the offset

        // Q16.16 times Q16.16, upper bits keep the Q16.16 result
        assign prod  = d * $signed(LOG2E_Q);
        assign ipart = prod[63:32];
        assign mant  = ONE_Q + {16'b0, prod[31:16]};

        // Shift amount is -k, only meaningful below 17
        assign sh = 5'(-ipart);

        // Anything at or beyond 2^-17 drops out of the 16 fraction bits
        assign y[i] = (ipart <= -17) ? '0 : elem_t'(mant >> sh);
    end

endmodule

// File: rtl/ln_approx.sv
// Natural log of the exp sum by leading-one range reduction, combinational, result in Q16.16
module ln_approx (
    input  softmax_pkg::sum_t  sum,
    output softmax_pkg::elem_t ln
);
    import softmax_pkg::*;

    logic [$clog2(SUM_W)-1:0] lead;   // Leading-one position
    logic [$clog2(SUM_W)-1:0] shift;  // Exponent k
    sum_t                     mant;

    // Highest set bit wins
    always_comb begin
        lead = '0;
        for (int b = 0; b < SUM_W; b++) begin
            if (sum[b]) begin
                lead = b[$clog2(SUM_W)-1:0];
            end
        end
    end

    // The max lane contributes exactly 1.0, so the sum never falls below ONE_Q
    assign shift = (lead > FRAC_W) ? lead - FRAC_W[$clog2(SUM_W)-1:0] : '0;

    assign mant = sum >> shift;  // m in [1, 2)

    // ln(sum) = k*ln2 + ln(m), ln(m) taken as m - 1
    assign ln = elem_t'(ELEM_W'(shift) * LN2_Q + mant[ELEM_W-1:0] - ONE_Q);

endmodule

// File: rtl/softmax_ctrl.sv
// Three-pass softmax sequencer driving buffer, exp offset, accumulator and the output register
module softmax_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  softmax_pkg::tile_t   x_tile,
    input  logic                 tile_in_valid,
    input  softmax_pkg::tile_t   rd_data,
    input  softmax_pkg::tile_t   exp_out,
    input  softmax_pkg::elem_t   ln_out,
    output softmax_pkg::buf_wr_t buf_wr,
    output softmax_pkg::addr_t   rd_addr,
    output softmax_pkg::elem_t   offset,
    output logic                 acc_clear,
    output logic                 acc_add,
    output softmax_pkg::tile_t   y_tile,
    output logic                 tile_out_valid,
    output logic                 done
);
    import softmax_pkg::*;

    state_t          state_q;
    state_t          state_d;
    logic [ADDR_W:0] step_q;      // Tile count in LOAD, cycle count in SUM and OUT
    logic            step_en;
    logic            load_last;
    logic            pass_last;
    logic            rd_req;
    logic            out_pend;    // Read data of the OUT pass is on rd_data

    elem_t max_q;
    elem_t tile_max;
    elem_t ln_q;

    assign load_last = (step_q == (ADDR_W+1)'(NUM_TILES - 1));
    assign pass_last = (step_q == (ADDR_W+1)'(NUM_TILES));

    // One read per cycle for the first NUM_TILES steps of SUM and OUT
    assign rd_req  = ((state_q == SUM) || (state_q == OUT)) && (step_q < NUM_TILES);
    assign rd_addr = step_q[ADDR_W-1:0];

    assign step_en = ((state_q == LOAD) && tile_in_valid) || (state_q == SUM) ||
                     (state_q == OUT);

    // Strobes outside LOAD never reach the buffer
    assign buf_wr = '{we: (state_q == LOAD) && tile_in_valid, addr: step_q[ADDR_W-1:0],
                      data: x_tile};

    assign acc_clear = (state_q == LOAD);  // Sum held at zero until the SUM pass

    // Normalize by max first, then by max + ln(sum) in the output pass
    assign offset = (state_q == OUT) ? max_q + ln_q : max_q;

    // Running max including the incoming tile
    always_comb begin
        tile_max = max_q;
        for (int i = 0; i < TILE_SIZE; i++) begin
            if (x_tile[i] > tile_max) begin
                tile_max = x_tile[i];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, DONE: begin
                if (start) state_d = LOAD;
            end
            LOAD: begin
                if (tile_in_valid && load_last) state_d = SUM;
            end
            SUM: begin
                if (pass_last) state_d = LN;  // Extra cycle lets the last add land
            end
            LN: begin
                state_d = OUT;
            end
            OUT: begin
                if (pass_last) state_d = DONE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q        <= IDLE;
            step_q         <= '0;
            acc_add        <= 1'b0;
            out_pend       <= 1'b0;
            tile_out_valid <= 1'b0;
            y_tile         <= '0;
            done           <= 1'b0;
        end else begin
            state_q <= state_d;

            if (state_q != state_d) begin
                step_q <= '0;
            end else if (step_en) begin
                step_q <= step_q + 1'b1;
            end

            acc_add  <= rd_req && (state_q == SUM);  // Lines up with rd_data
            out_pend <= rd_req && (state_q == OUT);

            // Output register, valid two cycles after the read address
            tile_out_valid <= out_pend;
            if (out_pend) begin
                y_tile <= exp_out;
            end

            if ((state_q != LOAD) && (state_d == LOAD)) begin
                done <= 1'b0;   // Start clears done
            end else if (state_q == DONE) begin
                done <= 1'b1;   // One cycle after the last output tile
            end
        end
    end

    // Running max over LOAD, ln(sum) latched in LN
    always_ff @(posedge clk) begin
        if ((state_q != LOAD) && (state_d == LOAD)) begin
            max_q <= {1'b1, {(ELEM_W-1){1'b0}}};  // Most negative value
        end else if (buf_wr.we) begin
            max_q <= tile_max;
        end

        if (state_q == LN) begin
            ln_q <= ln_out;
        end
    end

endmodule

// File: rtl/softmax_pkg.sv
// Shared sizes, Q16.16 constants and types for the tiled softmax design; import into each module
package softmax_pkg;

    // Element format, signed Q16.16
    localparam int ELEM_W = 32;
    localparam int FRAC_W = 16;

    // Vector geometry
    localparam int TILE_SIZE      = 8;
    localparam int TOTAL_ELEMENTS = 64;                   // Must be a multiple of TILE_SIZE
    localparam int NUM_TILES      = TOTAL_ELEMENTS / TILE_SIZE;
    localparam int ADDR_W         = $clog2(NUM_TILES);

    // Headroom for summing TOTAL_ELEMENTS values of at most 1.0
    localparam int SUM_W = ELEM_W + $clog2(TOTAL_ELEMENTS + 1);

    // Fixed-point constants
    localparam logic [ELEM_W-1:0] ONE_Q   = 32'h0001_0000; // 1.0
    localparam logic [ELEM_W-1:0] LN2_Q   = 32'h0000_B172; // ln(2) ~ 0.693147
    localparam logic [ELEM_W-1:0] LOG2E_Q = 32'h0001_7154; // log2(e) ~ 1.442695

    typedef logic signed [ELEM_W-1:0] elem_t;

    // Lane 0 is the most significant slice, matching the stream order
    typedef elem_t [0:TILE_SIZE-1] tile_t;

    typedef logic [SUM_W-1:0] sum_t;                      // Unsigned Q16.16 running sum

    typedef logic [ADDR_W-1:0] addr_t;

    // Write side of the tile buffer
    typedef struct packed {
        logic  we;
        addr_t addr;
        tile_t data;
    } buf_wr_t;

    // Controller passes
    typedef enum logic [2:0] {
        IDLE = 3'd0,
        LOAD = 3'd1,   // Store tiles, track max
        SUM  = 3'd2,   // Accumulate exp(x - max)
        LN   = 3'd3,   // Latch ln(sum)
        OUT  = 3'd4,   // Stream exp(x - max - ln(sum))
        DONE = 3'd5
    } state_t;

endpackage

// File: rtl/softmax_top.sv
// Softmax over one tiled vector of Q16.16 values; start, stream tiles in, collect tiles out
module softmax_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  softmax_pkg::tile_t x_tile,
    input  logic               tile_in_valid,
    output softmax_pkg::tile_t y_tile,
    output logic               tile_out_valid,
    output logic               done
);
    import softmax_pkg::*;

    buf_wr_t buf_wr;
    addr_t   rd_addr;
    tile_t   rd_data;
    tile_t   exp_out;
    elem_t   offset;
    elem_t   ln_out;
    sum_t    sum;
    logic    acc_clear;
    logic    acc_add;

    softmax_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .x_tile         (x_tile),
        .tile_in_valid  (tile_in_valid),
        .rd_data        (rd_data),
        .exp_out        (exp_out),
        .ln_out         (ln_out),
        .buf_wr         (buf_wr),
        .rd_addr        (rd_addr),
        .offset         (offset),
        .acc_clear      (acc_clear),
        .acc_add        (acc_add),
        .y_tile         (y_tile),
        .tile_out_valid (tile_out_valid),
        .done           (done)
    );

    tile_buffer u_buf (
        .clk     (clk),
        .wr      (buf_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Shared by the sum pass and the output pass
    exp_tile u_exp (
        .x      (rd_data),
        .offset (offset),
        .y      (exp_out)
    );

    sum_accumulator u_acc (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (acc_clear),
        .add   (acc_add),
        .tile  (exp_out),
        .sum   (sum)
    );

    ln_approx u_ln (
        .sum (sum),
        .ln  (ln_out)
    );

endmodule

// File: rtl/sum_accumulator.sv
// Running sum of all lanes of exponentiated tiles, cleared by the controller before each sum pass
module sum_accumulator (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear,
    input  logic               add,
    input  softmax_pkg::tile_t tile,
    output softmax_pkg::sum_t  sum
);
    import softmax_pkg::*;

    sum_t tile_total;

    // Lanes are non-negative exp results
    always_comb begin
        tile_total = '0;
        for (int i = 0; i < TILE_SIZE; i++) begin
            tile_total = tile_total + sum_t'($unsigned(tile[i]));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum <= '0;
        end else if (clear) begin  // Clear has priority
            sum <= '0;
        end else if (add) begin
            sum <= sum + tile_total;
        end
    end

endmodule

// File: rtl/tile_buffer.sv
// Tile store for one vector, written during the load pass and read back by the later passes
module tile_buffer (
    input  logic                 clk,
    input  softmax_pkg::buf_wr_t wr,
    input  softmax_pkg::addr_t   rd_addr,
    output softmax_pkg::tile_t   rd_data
);
    import softmax_pkg::*;

    tile_t mem [NUM_TILES];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
        rd_data <= mem[rd_addr];  // One cycle read latency
    end

endmodule

// File: tb.f
+incdir+include
rtl/softmax_pkg.sv
rtl/tile_buffer.sv
rtl/exp_tile.sv
rtl/ln_approx.sv
rtl/sum_accumulator.sv
rtl/softmax_ctrl.sv
rtl/softmax_top.sv
tests/tb_softmax.sv

// File: include/softmax_model.svh
// Bit-exact reference exp, ln and whole-vector softmax for the testbench; include after softmax_pkg
`ifndef SOFTMAX_MODEL_SVH
`define SOFTMAX_MODEL_SVH

// exp(x - offset) as 2^k * (1 + f) after scaling by log2(e)
function automatic elem_t exp_q(elem_t x, elem_t offset);
    elem_t              d;
    logic signed [63:0] scaled;
    int                 k;
    logic [ELEM_W-1:0]  f;
    d = x - offset;
    if (d > 0) begin
        d = '0;
    end
    scaled = d * $signed(LOG2E_Q);
    scaled = scaled >>> FRAC_W;           // Back to Q16.16, rounded toward minus infinity
    k      = int'(scaled >>> FRAC_W);     // Floor, never positive
    f      = ELEM_W'(scaled[FRAC_W-1:0]);
    if (-k >= 17) begin
        return '0;
    end
    return elem_t'((ONE_Q + f) >> (-k));
endfunction

// ln of an unsigned Q16.16 sum, k*ln2 + (m - 1) after leading-one reduction
function automatic elem_t ln_q(sum_t s);
    int   p;
    int   k;
    sum_t m;
    p = SUM_W - 1;
    while ((p > 0) && !s[p]) begin
        p--;
    end
    k = p - FRAC_W;
    if (k < 0) begin
        k = 0;
    end
    m = s >> k;
    return elem_t'(k * int'(LN2_Q) + int'(m[ELEM_W-1:0]) - int'(ONE_Q));
endfunction

// Expected output tiles for one full vector
function automatic void softmax_vec(input tile_t x_tiles [NUM_TILES],
                                    output tile_t y_tiles [NUM_TILES]);
    elem_t mx;
    sum_t  acc;
    elem_t ln_sum;
    mx  = {1'b1, {(ELEM_W-1){1'b0}}};
    acc = '0;
    for (int t = 0; t < NUM_TILES; t++) begin
        for (int l = 0; l < TILE_SIZE; l++) begin
            if (x_tiles[t][l] > mx) mx = x_tiles[t][l];
        end
    end
    for (int t = 0; t < NUM_TILES; t++) begin
        for (int l = 0; l < TILE_SIZE; l++) begin
            acc = acc + sum_t'($unsigned(exp_q(x_tiles[t][l], mx)));
        end
    end
    ln_sum = ln_q(acc);
    for (int t = 0; t < NUM_TILES; t++) begin
        for (int l = 0; l < TILE_SIZE; l++) begin
            y_tiles[t][l] = exp_q(x_tiles[t][l], mx + ln_sum);
        end
    end
endfunction

`endif

// File: tests/tb_softmax.sv
// Testbench for softmax_top; runs several vectors and compares every output lane with the model
module tb_softmax;
    timeunit 1ns;
    timeprecision 1ps;

    import softmax_pkg::*;

    `include "softmax_model.svh"

    localparam int RESET_CYCLES = 3;
    localparam int NUM_RUNS     = 5;
    localparam int CYCLE_LIMIT  = NUM_RUNS * (3 * NUM_TILES + 30) + RESET_CYCLES;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  start;
    tile_t x_tile;
    logic  tile_in_valid;
    tile_t y_tile;
    logic  tile_out_valid;
    logic  done;

    tile_t vec [NUM_TILES];         // Vector for the next run
    tile_t expected_tiles [$];      // Model outputs still to arrive
    int    checks = 0;
    int    errors = 0;
    int    cycle = 0;
    int    run_outs = 0;            // Output tiles seen in the current run
    int    last_out_cycle = 0;

    softmax_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .x_tile         (x_tile),
        .tile_in_valid  (tile_in_valid),
        .y_tile         (y_tile),
        .tile_out_valid (tile_out_valid),
        .done           (done)
    );

    always #10 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, the DUT did not finish in time", cycle);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, want);
        end
    endtask

    task automatic flag_error(input string msg);
        errors++;
        $display("Error at cycle %0d: %s", cycle, msg);
    endtask

    // Sampled on the falling edge, away from the DUT updates
    always @(negedge clk) begin
        tile_t want;
        if (rst_n && tile_out_valid) begin
            if (expected_tiles.size() == 0) begin
                flag_error("output tile arrived when none was expected");
            end else begin
                want = expected_tiles.pop_front();
                if ((run_outs > 0) && (cycle != last_out_cycle + 1)) begin
                    flag_error("output tiles are not on consecutive cycles");
                end
                for (int l = 0; l < TILE_SIZE; l++) begin
                    check_value($sformatf("y_tile[%0d] of tile %0d", l, run_outs),
                                y_tile[l], want[l]);
                end
                run_outs++;
                last_out_cycle = cycle;
            end
        end
    end

    function automatic elem_t rand_elem();
        int r;
        r = int'($urandom_range(0, 16 * 65536));
        return elem_t'(r - 8 * 65536);  // Within +-8.0
    endfunction

    function automatic tile_t junk_tile();
        tile_t t;
        for (int l = 0; l < TILE_SIZE; l++) begin
            t[l] = elem_t'($urandom());
        end
        return t;
    endfunction

    task automatic make_random();
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int l = 0; l < TILE_SIZE; l++) begin
                vec[t][l] = rand_elem();
            end
        end
    endtask

    task automatic make_equal(input elem_t value);
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int l = 0; l < TILE_SIZE; l++) begin
                vec[t][l] = value;
            end
        end
    endtask

    // One element at 5.0, the rest far enough below to exp to zero
    task automatic make_peak();
        int pos;
        pos = int'($urandom_range(0, TOTAL_ELEMENTS - 1));
        make_equal(32'hFFF8_0000);
        vec[pos / TILE_SIZE][pos % TILE_SIZE] = 32'h0005_0000;
    endtask

    // Strobes with junk data that the DUT must ignore
    task automatic idle_strobes(input int n);
        repeat (n) begin
            @(posedge clk);
            x_tile        <= junk_tile();
            tile_in_valid <= 1'b1;
        end
        @(posedge clk);
        tile_in_valid <= 1'b0;
    endtask

    task automatic load_tiles();
        int gap;
        for (int t = 0; t < NUM_TILES; t++) begin
            gap = int'($urandom_range(0, 1));
            repeat (gap) begin
                @(posedge clk);
                x_tile        <= junk_tile();
                tile_in_valid <= 1'b0;
            end
            @(posedge clk);
            x_tile        <= vec[t];
            tile_in_valid <= 1'b1;
        end
        @(posedge clk);
        tile_in_valid <= 1'b0;
    endtask

    task automatic run_vector(input string label, input bit stray_start);
        tile_t want_tiles [NUM_TILES];
        bit    sent;
        sent = 1'b0;
        softmax_vec(vec, want_tiles);
        for (int t = 0; t < NUM_TILES; t++) begin
            expected_tiles.push_back(want_tiles[t]);
        end
        run_outs = 0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value({label, ": done after start"}, 32'(done), 32'h0);
        load_tiles();
        while (!done) begin
            @(posedge clk);
            if (stray_start && !sent && (run_outs >= 2)) begin  // Lands in the OUT pass
                start <= 1'b1;
                sent = 1'b1;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
        end
        if (run_outs != NUM_TILES) begin
            flag_error($sformatf("%s: expected %0d output tiles, saw %0d",
                                 label, NUM_TILES, run_outs));
        end
        if (cycle != last_out_cycle + 1) begin
            flag_error({label, ": done did not rise the cycle after the last output tile"});
        end
        if (expected_tiles.size() != 0) begin
            flag_error({label, ": output tiles are missing"});
            expected_tiles.delete();
        end
    endtask

    initial begin
        void'($urandom(32'hcd555881));
        rst_n         = 1'b0;
        start         = 1'b0;
        x_tile        = '0;
        tile_in_valid = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Outputs right after reset
        @(negedge clk);
        check_value("tile_out_valid after reset", 32'(tile_out_valid), 32'h0);
        check_value("done after reset", 32'(done), 32'h0);
        for (int l = 0; l < TILE_SIZE; l++) begin
            check_value($sformatf("y_tile[%0d] after reset", l), y_tile[l], 32'h0);
        end

        idle_strobes(3);
        make_random();
        run_vector("random vector", 1'b0);

        make_equal(32'h0002_8000);                     // 2.5 everywhere
        run_vector("equal vector", 1'b0);

        make_peak();
        run_vector("single peak", 1'b0);

        idle_strobes(3);                               // Junk while done is high
        make_random();
        run_vector("stray start", 1'b1);

        @(negedge clk);
        check_value("done before restart", 32'(done), 32'h1);
        make_random();
        run_vector("restart", 1'b0);

        repeat (3) @(posedge clk);  // Room for any extra tile to show up
        @(negedge clk);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
